//--- rv_loader_pkg.sv
`default_nettype none

package rv_loader_pkg;

    ////////////////////////////////////////
    // widths and defaults
    ////////////////////////////////////////

    // program memory word, one rv32 instruction
    localparam int DATA_WIDTH = 32;

    // 256 words unless the top level says otherwise
    localparam int ADDR_WIDTH_DEFAULT = 8;

    // clocks per uart bit
    localparam int CLKS_PER_BIT_DEFAULT = 16;

    ////////////////////////////////////////
    // state encodings
    ////////////////////////////////////////

    // uart receiver frame phases
    typedef enum logic [1:0] {
        UART_IDLE  = 2'd0,
        UART_START = 2'd1,
        UART_DATA  = 2'd2,
        UART_STOP  = 2'd3
    } uart_state_t;

    // loader, either waiting for prog or packing bytes
    typedef enum logic {
        LD_IDLE = 1'b0,
        LD_LOAD = 1'b1
    } loader_state_t;

endpackage

`default_nettype wire

//--- uart_rx.sv
`timescale 1ns/100ps
`default_nettype none

module uart_rx #(
    parameter int CLKS_PER_BIT = rv_loader_pkg::CLKS_PER_BIT_DEFAULT
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       rx,
    output logic [7:0] rx_data,
    output logic       rx_valid,
    output logic       frame_err
);
    import rv_loader_pkg::*;

    // counter wide enough for a full bit time
    localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);
    // last clock of a bit, and last clock of half a bit
    localparam logic [CNT_W-1:0] BIT_LAST  = CNT_W'(CLKS_PER_BIT - 1);
    localparam logic [CNT_W-1:0] HALF_LAST = CNT_W'(CLKS_PER_BIT / 2 - 1);

    logic             rx_meta;
    logic             rx_sync;
    logic             rx_prev;
    logic             start_edge;
    logic             bit_tick;
    uart_state_t      state;
    logic [CNT_W-1:0] clk_cnt;
    logic [2:0]       bit_idx;
    logic [7:0]       shift_reg;

    ////////////////////////////////////////
    // line synchronizer
    ////////////////////////////////////////

    // two flops, line idles high
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end
        else
        begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    // high to low on the synced line
    assign start_edge = rx_prev & ~rx_sync;
    // middle of a data or stop bit
    assign bit_tick = (clk_cnt == BIT_LAST);

    ////////////////////////////////////////
    // frame FSM
    ////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state     <= UART_IDLE;
            clk_cnt   <= '0;
            bit_idx   <= '0;
            rx_valid  <= 1'b0;
            frame_err <= 1'b0;
        end
        else
        begin
            // strobes last one clock
            rx_valid  <= 1'b0;
            frame_err <= 1'b0;
            case (state)
                UART_IDLE:
                begin
                    clk_cnt <= '0;
                    bit_idx <= '0;
                    if (start_edge)
                        state <= UART_START;
                end
                UART_START:
                begin
                    if (clk_cnt == HALF_LAST)
                    begin
                        clk_cnt <= '0;
                        // still low at mid-bit, else a glitch
                        state <= rx_sync ? UART_IDLE : UART_DATA;
                    end
                    else
                        clk_cnt <= clk_cnt + CNT_W'(1);
                end
                UART_DATA:
                begin
                    if (bit_tick)
                    begin
                        clk_cnt <= '0;
                        bit_idx <= bit_idx + 3'd1;
                        if (bit_idx == 3'd7)
                            state <= UART_STOP;
                    end
                    else
                        clk_cnt <= clk_cnt + CNT_W'(1);
                end
                UART_STOP:
                begin
                    if (bit_tick)
                    begin
                        clk_cnt <= '0;
                        // good stop bit gives a byte, bad one an error
                        rx_valid  <= rx_sync;
                        frame_err <= ~rx_sync;
                        state     <= UART_IDLE;
                    end
                    else
                        clk_cnt <= clk_cnt + CNT_W'(1);
                end
                default:
                    state <= UART_IDLE;
            endcase
        end
    end

    // data path, lsb arrives first
    always_ff @(posedge clk)
    begin
        if (state == UART_DATA && bit_tick)
            shift_reg <= {rx_sync, shift_reg[7:1]};
        if (state == UART_STOP && bit_tick && rx_sync)
            rx_data <= shift_reg;
    end

endmodule

`default_nettype wire

//--- prog_loader.sv
`timescale 1ns/100ps
`default_nettype none

module prog_loader #(
    parameter int ADDR_WIDTH = rv_loader_pkg::ADDR_WIDTH_DEFAULT
) (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 prog,
    input  logic [7:0]                           rx_data,
    input  logic                                 rx_valid,
    output logic                                 mem_we,
    output logic [ADDR_WIDTH-1:0]                mem_waddr,
    output logic [rv_loader_pkg::DATA_WIDTH-1:0] mem_wdata,
    output logic [ADDR_WIDTH:0]                  words_loaded
);
    import rv_loader_pkg::*;

    logic          prog_q;
    logic          prog_rise;
    logic          prog_fall;
    logic          take_byte;
    logic          word_done;
    loader_state_t state;
    logic [1:0]    byte_count;
    // lower three lanes of the word in progress
    logic [23:0]   word_buf;

    assign prog_rise = prog & ~prog_q;
    assign prog_fall = ~prog & prog_q;
    // bytes only count while loading, never on the falling edge
    assign take_byte = (state == LD_LOAD) && rx_valid && !prog_fall;
    assign word_done = take_byte && (byte_count == 2'd3);

    ////////////////////////////////////////
    // state and counters
    ////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            prog_q       <= 1'b0;
            state        <= LD_IDLE;
            byte_count   <= '0;
            mem_we       <= 1'b0;
            mem_waddr    <= '0;
            words_loaded <= '0;
        end
        else
        begin
            prog_q <= prog;
            // write one clock after the fourth byte
            mem_we <= word_done;
            case (state)
                LD_IDLE:
                begin
                    if (prog_rise)
                    begin
                        state      <= LD_LOAD;
                        byte_count <= '0;
                    end
                end
                LD_LOAD:
                begin
                    // partial word dropped on prog low
                    if (prog_fall)
                    begin
                        state      <= LD_IDLE;
                        byte_count <= '0;
                    end
                    else if (take_byte)
                        byte_count <= byte_count + 2'd1;
                end
                default:
                    state <= LD_IDLE;
            endcase
            // new load starts at word 0
            if (prog_rise)
            begin
                mem_waddr    <= '0;
                words_loaded <= '0;
            end
            else if (mem_we)
            begin
                // address wraps, count saturates
                mem_waddr <= mem_waddr + 1'b1;
                if (words_loaded != '1)
                    words_loaded <= words_loaded + 1'b1;
            end
        end
    end

    ////////////////////////////////////////
    // word assembly, little endian
    ////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (take_byte)
        begin
            case (byte_count)
                2'd0: word_buf[7:0]   <= rx_data;
                2'd1: word_buf[15:8]  <= rx_data;
                2'd2: word_buf[23:16] <= rx_data;
                2'd3: mem_wdata       <= {rx_data, word_buf};
            endcase
        end
    end

endmodule

`default_nettype wire

//--- prog_mem.sv
`timescale 1ns/100ps
`default_nettype none

module prog_mem #(
    parameter int ADDR_WIDTH = rv_loader_pkg::ADDR_WIDTH_DEFAULT
) (
    input  logic                                 clk,
    input  logic                                 we,
    input  logic [ADDR_WIDTH-1:0]                waddr,
    input  logic [rv_loader_pkg::DATA_WIDTH-1:0] wdata,
    input  logic [ADDR_WIDTH-1:0]                rd_addr,
    output logic [rv_loader_pkg::DATA_WIDTH-1:0] rd_data
);
    import rv_loader_pkg::*;

    localparam int DEPTH = 2 ** ADDR_WIDTH;

    // one word per instruction
    logic [DATA_WIDTH-1:0] mem [DEPTH];

    ////////////////////////////////////////
    // write port
    ////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (we)
            mem[waddr] <= wdata;
    end

    ////////////////////////////////////////
    // read port
    ////////////////////////////////////////

    // registered, one clock latency
    // same-address write in the same cycle gives old data
    always_ff @(posedge clk)
    begin
        rd_data <= mem[rd_addr];
    end

endmodule

`default_nettype wire

//--- rv_loader_top.sv
`timescale 1ns/100ps
`default_nettype none

module rv_loader_top #(
    parameter int CLKS_PER_BIT = rv_loader_pkg::CLKS_PER_BIT_DEFAULT,
    parameter int ADDR_WIDTH   = rv_loader_pkg::ADDR_WIDTH_DEFAULT
) (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 rx,
    input  logic                                 prog,
    input  logic [ADDR_WIDTH-1:0]                rd_addr,
    output logic [rv_loader_pkg::DATA_WIDTH-1:0] rd_data,
    output logic [ADDR_WIDTH:0]                  words_loaded,
    output logic                                 frame_err
);
    import rv_loader_pkg::*;

    // receiver to loader
    logic [7:0]            rx_data;
    logic                  rx_valid;
    // loader to memory
    logic                  mem_we;
    logic [ADDR_WIDTH-1:0] mem_waddr;
    logic [DATA_WIDTH-1:0] mem_wdata;

    ////////////////////////////////////////
    // serial in, loader, program memory
    ////////////////////////////////////////

    uart_rx #(
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) u_uart_rx (
        .clk       (clk),
        .reset     (reset),
        .rx        (rx),
        .rx_data   (rx_data),
        .rx_valid  (rx_valid),
        .frame_err (frame_err)
    );

    prog_loader #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) u_prog_loader (
        .clk          (clk),
        .reset        (reset),
        .prog         (prog),
        .rx_data      (rx_data),
        .rx_valid     (rx_valid),
        .mem_we       (mem_we),
        .mem_waddr    (mem_waddr),
        .mem_wdata    (mem_wdata),
        .words_loaded (words_loaded)
    );

    prog_mem #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) u_prog_mem (
        .clk     (clk),
        .we      (mem_we),
        .waddr   (mem_waddr),
        .wdata   (mem_wdata),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

endmodule

`default_nettype wire

//--- rv_loader_checker.sv
`timescale 1ns/100ps
`default_nettype none

module rv_loader_checker #(
    parameter int CLKS_PER_BIT = rv_loader_pkg::CLKS_PER_BIT_DEFAULT,
    parameter int ADDR_WIDTH   = rv_loader_pkg::ADDR_WIDTH_DEFAULT
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  rx,
    input  logic                  prog,
    input  logic [ADDR_WIDTH-1:0] rd_addr,
    input  logic [31:0]           rd_data,
    input  logic [ADDR_WIDTH:0]   words_loaded,
    input  logic                  frame_err,
    input  logic [7:0]            sent_byte,
    input  logic                  sent_strobe,
    input  logic                  load_start,
    input  logic                  check_en,
    input  logic                  err_expect,
    output int                    value_errors,
    output int                    err_pulses
);
    // line counts as idle after this many high clocks
    localparam int IDLE_CLKS = 12 * CLKS_PER_BIT;
    localparam int DEPTH     = 2 ** ADDR_WIDTH;

    logic [31:0]           image [DEPTH];
    logic [7:0]            lanes [3];
    logic [1:0]            lane;
    logic [ADDR_WIDTH-1:0] exp_addr;
    logic [ADDR_WIDTH:0]   exp_count;
    logic                  prog_q;
    logic                  en_q;
    logic [ADDR_WIDTH-1:0] addr_q;
    int                    high_clks;

    // reference word with the first byte in the low lane
    function automatic logic [31:0] pack_word(input logic [7:0] b0, input logic [7:0] b1,
                                              input logic [7:0] b2, input logic [7:0] b3);
        return {b3, b2, b1, b0};
    endfunction

    initial
    begin
        value_errors = 0;
        err_pulses   = 0;
    end

    ////////////////////////////////////////
    // expected memory image and count
    ////////////////////////////////////////

    always @(posedge clk)
    begin
        if (reset)
        begin
            lane      <= '0;
            exp_addr  <= '0;
            exp_count <= '0;
            prog_q    <= 1'b0;
            en_q      <= 1'b0;
            high_clks <= 0;
        end
        else
        begin
            prog_q <= prog;
            en_q   <= check_en;
            addr_q <= rd_addr;
            // idle time of the serial line
            if (!rx)
                high_clks <= 0;
            else if (high_clks < IDLE_CLKS)
                high_clks <= high_clks + 1;
            if (load_start)
            begin
                lane      <= '0;
                exp_addr  <= '0;
                exp_count <= '0;
            end
            // prog low drops a partial word
            else if (prog_q && !prog)
                lane <= '0;
            else if (sent_strobe)
            begin
                if (lane == 2'd3)
                begin
                    image[exp_addr] <= pack_word(lanes[0], lanes[1], lanes[2], sent_byte);
                    exp_addr        <= exp_addr + 1'b1;
                    lane            <= '0;
                    if (exp_count != '1)
                        exp_count <= exp_count + 1'b1;
                end
                else
                begin
                    lanes[lane] <= sent_byte;
                    lane        <= lane + 2'd1;
                end
            end
        end
    end

    ////////////////////////////////////////
    // compare on the falling edge
    ////////////////////////////////////////

    always @(negedge clk)
    begin
        if (!reset)
        begin
            // read data belongs to the address of the cycle before
            if (en_q && rd_data !== image[addr_q])
            begin
                value_errors++;
                $display("error %0d ns: rd_data %h at address %0d, expected %h",
                         $time, rd_data, addr_q, image[addr_q]);
            end
            if (!prog && high_clks >= IDLE_CLKS && words_loaded !== exp_count)
            begin
                value_errors++;
                $display("error %0d ns: words_loaded %0d, expected %0d",
                         $time, words_loaded, exp_count);
            end
            if (frame_err)
            begin
                err_pulses++;
                if (!err_expect)
                begin
                    value_errors++;
                    $display("error %0d ns: frame_err high without a bad frame", $time);
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- tb_rv_loader.sv
`timescale 1ns/100ps
`default_nettype none

module tb_rv_loader;

    localparam int CLKS_PER_BIT = 8;
    localparam int ADDR_WIDTH   = 4;
    localparam int DEPTH        = 2 ** ADDR_WIDTH;
    // longest wait for any DUT event, in clocks
    localparam int WAIT_LIMIT   = 40 * CLKS_PER_BIT;

    logic                  clk;
    logic                  reset;
    logic                  rx;
    logic                  prog;
    logic [ADDR_WIDTH-1:0] rd_addr;
    logic [31:0]           rd_data;
    logic [ADDR_WIDTH:0]   words_loaded;
    logic                  frame_err;
    logic [7:0]            sent_byte;
    logic                  sent_strobe;
    logic                  load_start;
    logic                  check_en;
    logic                  err_expect;
    logic [7:0]            lfsr;
    logic [7:0]            bad_byte;
    int                    value_errors;
    int                    err_pulses;
    int                    timeouts;

    rv_loader_top #(.CLKS_PER_BIT(CLKS_PER_BIT), .ADDR_WIDTH(ADDR_WIDTH)) UUT (
        .clk(clk), .reset(reset), .rx(rx), .prog(prog), .rd_addr(rd_addr),
        .rd_data(rd_data), .words_loaded(words_loaded), .frame_err(frame_err)
    );

    rv_loader_checker #(.CLKS_PER_BIT(CLKS_PER_BIT), .ADDR_WIDTH(ADDR_WIDTH)) u_checker (
        .clk(clk), .reset(reset), .rx(rx), .prog(prog), .rd_addr(rd_addr),
        .rd_data(rd_data), .words_loaded(words_loaded), .frame_err(frame_err),
        .sent_byte(sent_byte), .sent_strobe(sent_strobe), .load_start(load_start),
        .check_en(check_en), .err_expect(err_expect), .value_errors(value_errors),
        .err_pulses(err_pulses)
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // galois lfsr, x^8 + x^6 + x^5 + x^4 + 1
    function automatic logic [7:0] lfsr_step(input logic [7:0] s);
        return s[0] ? ((s >> 1) ^ 8'hB8) : (s >> 1);
    endfunction

    // one lfsr step per bit
    task automatic random_byte(output logic [7:0] b);
        for (int i = 0; i < 8; i++)
        begin
            b[i] = lfsr[0];
            lfsr = lfsr_step(lfsr);
        end
    endtask

    task automatic print_counts();
        $display("value errors: %0d, timeouts: %0d", value_errors, timeouts);
    endtask

    task automatic timeout_fail(input string what);
        timeouts++;
        $display("timeout: %s did not happen in time", what);
        print_counts();
        $display("TESTBENCH FAILED");
        $finish;
    endtask

    ////////////////////////////////////////
    // serial frames, 8N1 plus a two-bit gap
    ////////////////////////////////////////

    task automatic send_frame(input logic [7:0] data, input logic bad_stop);
        rx = 1'b0;
        repeat (CLKS_PER_BIT) @(negedge clk);
        for (int i = 0; i < 8; i++)
        begin
            rx = data[i];
            repeat (CLKS_PER_BIT) @(negedge clk);
        end
        rx = ~bad_stop;
        repeat (CLKS_PER_BIT) @(negedge clk);
        rx = 1'b1;
        repeat (2 * CLKS_PER_BIT) @(negedge clk);
    endtask

    // report only bytes the loader should take
    task automatic send_random_bytes(input int n, input logic report);
        logic [7:0] b;
        for (int i = 0; i < n; i++)
        begin
            random_byte(b);
            send_frame(b, 1'b0);
            if (report)
            begin
                sent_byte   = b;
                sent_strobe = 1'b1;
                @(negedge clk);
                sent_strobe = 1'b0;
            end
        end
    endtask

    task automatic begin_load();
        prog       = 1'b1;
        load_start = 1'b1;
        @(negedge clk);
        load_start = 1'b0;
    endtask

    // idle long enough for the count check
    task automatic end_load();
        repeat (CLKS_PER_BIT) @(negedge clk);
        prog = 1'b0;
        repeat (14 * CLKS_PER_BIT) @(negedge clk);
    endtask

    task automatic wait_words(input logic [ADDR_WIDTH:0] target);
        int n;
        n = 0;
        while (words_loaded !== target && n < WAIT_LIMIT)
        begin
            @(negedge clk);
            n++;
        end
        if (words_loaded !== target)
            timeout_fail("word count");
    endtask

    task automatic wait_frame_err(input int target);
        int n;
        n = 0;
        while (err_pulses < target && n < WAIT_LIMIT)
        begin
            @(negedge clk);
            n++;
        end
        if (err_pulses < target)
            timeout_fail("frame error pulse");
    endtask

    // one address per clock, checker compares
    task automatic read_back(input int count);
        for (int a = 0; a < count; a++)
        begin
            rd_addr  = a[ADDR_WIDTH-1:0];
            check_en = 1'b1;
            @(negedge clk);
        end
        check_en = 1'b0;
        repeat (2) @(negedge clk);
    endtask

    ////////////////////////////////////////
    // stimulus sequence
    ////////////////////////////////////////

    initial
    begin
        reset       = 1'b1;
        rx          = 1'b1;
        prog        = 1'b0;
        rd_addr     = '0;
        sent_byte   = '0;
        sent_strobe = 1'b0;
        load_start  = 1'b0;
        check_en    = 1'b0;
        err_expect  = 1'b0;
        timeouts    = 0;
        lfsr        = 8'd61;
        repeat (5) @(negedge clk);
        reset = 1'b0;
        // quiet line after reset, count stays zero
        repeat (14 * CLKS_PER_BIT) @(negedge clk);
        // eight full words
        begin_load();
        send_random_bytes(32, 1'b1);
        wait_words(8);
        end_load();
        read_back(8);
        // bad stop bit inside a word, then a dropped partial word
        begin_load();
        send_random_bytes(2, 1'b1);
        err_expect = 1'b1;
        random_byte(bad_byte);
        send_frame(bad_byte, 1'b1);
        wait_frame_err(1);
        err_expect = 1'b0;
        send_random_bytes(6, 1'b1);
        wait_words(2);
        send_random_bytes(3, 1'b1);
        end_load();
        // ignored with prog low
        send_random_bytes(4, 1'b0);
        repeat (14 * CLKS_PER_BIT) @(negedge clk);
        read_back(8);
        // 18 words wrap the 16-word memory
        begin_load();
        send_random_bytes(72, 1'b1);
        wait_words(18);
        end_load();
        read_back(DEPTH);
        print_counts();
        if (value_errors == 0 && timeouts == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- rv_loader_top.f
rv_loader_pkg.sv
uart_rx.sv
prog_loader.sv
prog_mem.sv
rv_loader_top.sv
rv_loader_checker.sv
tb_rv_loader.sv

//--- run_sim.sh
#!/bin/sh
# build and run the loader testbench with verilator
verilator --binary --timing -Wno-fatal --top-module tb_rv_loader \
    -f rv_loader_top.f -o tb_rv_loader > build.log 2>&1 \
    && ./obj_dir/tb_rv_loader > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -q "TESTBENCH FAILED" sim.log && exit 1 || exit 0
